/* compile.f */
design/mem_maint_pkg.sv
design/boot_sequencer.sv
design/fill_load_engine.sv
design/readback_verifier.sv
design/mem_port_arbiter.sv
design/mem_maint_top.sv
testbench/mem_maint_checker.sv
testbench/tb_mem_maint.sv

/* design/boot_sequencer.sv */
/*
 * boot sequencer
 * steps reset, zero fill, load, verify and run on each engine's done flag
 */
`timescale 1ns/10ps

module boot_sequencer (
    input  logic                       clk,
    input  logic                       i_rst,
    input  logic                       i_calib_done,
    input  logic                       i_zero_done,
    input  logic                       i_load_done,
    input  logic                       i_verify_done,
    output mem_maint_pkg::boot_phase_e o_phase,
    output logic                       o_init_done
);
    import mem_maint_pkg::*;

    boot_phase_e r_next;

    always_comb begin
        r_next = o_phase;
        case (o_phase)
            PH_RESET:  r_next = PH_ZERO;
            PH_ZERO:   if (i_calib_done && i_zero_done) r_next = PH_LOAD;
            PH_LOAD:   if (i_load_done) r_next = PH_VERIFY;
            PH_VERIFY: if (i_verify_done) r_next = PH_RUN;
            default:   r_next = PH_RUN;    // run is terminal until reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_phase     <= PH_RESET;
            o_init_done <= 1'b0;
        end else begin
            o_phase <= r_next;
            if (r_next == PH_RUN)
                o_init_done <= 1'b1;   // rises together with PH_RUN
        end
    end

    // boot never steps back except through reset
    a_phase_forward: assert property (@(posedge clk) disable iff (i_rst)
        !$past(i_rst) |-> o_phase >= $past(o_phase));

endmodule

/* design/fill_load_engine.sv */
/*
 * fill and load engine
 * zero-fills the low region, then copies the loader stream from address 0
 * while summing the loaded words
 */
`timescale 1ns/10ps

module fill_load_engine #(
    parameter int FILL_BYTES  = 256,
    parameter int IMAGE_BYTES = 128
) (
    input  logic                              clk,
    input  logic                              i_rst,
    input  mem_maint_pkg::boot_phase_e        i_phase,
    input  logic                              i_calib_done,
    input  logic                              i_mem_busy,
    input  logic                              i_ld_valid,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_ld_data,
    output mem_maint_pkg::mem_op_e            o_op,
    output logic [mem_maint_pkg::ADDR_W-1:0]  o_addr,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_wdata,
    output logic                              o_ld_taken,
    output logic                              o_zero_done,
    output logic                              o_load_done,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_load_sum
);
    import mem_maint_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_STROBE,   // strobe up, waiting for busy
        WR_WAIT      // busy seen, waiting for completion
    } wr_state_e;

    wr_state_e          r_state;
    logic               w_zero_go;
    logic               w_load_go;
    logic [ADDR_W-1:0]  w_next;

    assign w_zero_go = (r_state == WR_IDLE) && (i_phase == PH_ZERO) && i_calib_done
                       && !o_zero_done && !i_mem_busy;
    assign w_load_go = (r_state == WR_IDLE) && (i_phase == PH_LOAD) && i_ld_valid
                       && !o_load_done && !i_mem_busy;
    assign w_next    = o_addr + ADDR_W'(WORD_BYTES);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            r_state     <= WR_IDLE;
            o_op        <= OP_NONE;
            o_addr      <= '0;
            o_ld_taken  <= 1'b0;
            o_zero_done <= 1'b0;
            o_load_done <= 1'b0;
            o_load_sum  <= '0;
        end else begin
            o_ld_taken <= 1'b0;
            case (r_state)
                WR_IDLE: begin
                    if (w_zero_go || w_load_go) begin
                        o_op    <= OP_WRITE;
                        r_state <= WR_STROBE;
                    end
                    if (w_load_go) begin
                        o_ld_taken <= 1'b1;
                        o_load_sum <= o_load_sum + i_ld_data;   // wraps at 32 bits
                    end
                end
                WR_STROBE: begin
                    if (i_mem_busy) begin
                        o_op    <= OP_NONE;
                        r_state <= WR_WAIT;
                    end
                end
                default: begin
                    if (!i_mem_busy) begin
                        r_state <= WR_IDLE;
                        if (i_phase == PH_ZERO && w_next == ADDR_W'(FILL_BYTES)) begin
                            o_zero_done <= 1'b1;
                            o_addr      <= '0;   // image starts at 0
                        end else begin
                            o_addr <= w_next;
                        end
                        if (i_phase == PH_LOAD && w_next == ADDR_W'(IMAGE_BYTES))
                            o_load_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    // write data held from strobe to completion
    always_ff @(posedge clk) begin
        if (w_zero_go)
            o_wdata <= '0;
        else if (w_load_go)
            o_wdata <= i_ld_data;
    end

    // a new write strobe never meets a busy port
    a_no_write_into_busy: assert property (@(posedge clk) disable iff (i_rst)
        $rose(o_op == OP_WRITE) |-> !i_mem_busy);

endmodule

/* design/mem_maint_pkg.sv */
/*
 * memory maintenance shared definitions
 * bus widths, CPU address mask, boot phases and engine memory ops
 */
package mem_maint_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BE_W       = 4;
    localparam int WORD_BYTES = 4;   // byte step between words

    // CPU addresses keep the low 26 bits
    localparam logic [ADDR_W-1:0] ADDR_MASK = 32'h03ff_ffff;

    // boot runs strictly in this order
    typedef enum logic [2:0] {
        PH_RESET  = 3'd0,
        PH_ZERO   = 3'd1,
        PH_LOAD   = 3'd2,
        PH_VERIFY = 3'd3,
        PH_RUN    = 3'd4
    } boot_phase_e;

    // engine request to the port arbiter
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } mem_op_e;

endpackage

/* design/mem_maint_top.sv */
/*
 * memory maintenance top
 * boot sequencing, fill/load, read-back verify and CPU port handover
 */
`timescale 1ns/10ps

module mem_maint_top #(
    parameter int FILL_BYTES  = 256,
    parameter int IMAGE_BYTES = 128
) (
    input  logic                              clk,
    input  logic                              i_rst,
    input  logic                              i_rd_en,
    input  logic                              i_wr_en,
    input  logic [mem_maint_pkg::ADDR_W-1:0]  i_addr,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_data,
    input  logic [mem_maint_pkg::BE_W-1:0]    i_ctrl,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_data,
    output logic                              o_busy,
    input  logic                              i_ld_valid,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_ld_data,
    output logic                              o_ld_taken,
    output logic                              o_mem_rd,
    output logic                              o_mem_wr,
    output logic [mem_maint_pkg::ADDR_W-1:0]  o_mem_addr,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_mem_wdata,
    output logic [mem_maint_pkg::BE_W-1:0]    o_mem_be,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_mem_rdata,
    input  logic                              i_mem_busy,
    input  logic                              i_calib_done,
    output logic                              o_init_done,
    output logic                              o_checksum_match
);
    import mem_maint_pkg::*;

    if (IMAGE_BYTES > FILL_BYTES || FILL_BYTES % WORD_BYTES != 0
        || IMAGE_BYTES % WORD_BYTES != 0) begin : g_bad_sizes
        $error("image must fit the fill region, both in whole words");
    end

    boot_phase_e        w_phase;
    logic               w_zero_done;
    logic               w_load_done;
    logic               w_verify_done;
    mem_op_e            w_fl_op;
    logic [ADDR_W-1:0]  w_fl_addr;
    logic [DATA_W-1:0]  w_fl_wdata;
    logic [DATA_W-1:0]  w_load_sum;
    mem_op_e            w_rb_op;
    logic [ADDR_W-1:0]  w_rb_addr;

    boot_sequencer u_seq (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_calib_done  (i_calib_done),
        .i_zero_done   (w_zero_done),
        .i_load_done   (w_load_done),
        .i_verify_done (w_verify_done),
        .o_phase       (w_phase),
        .o_init_done   (o_init_done)
    );

    fill_load_engine #(
        .FILL_BYTES  (FILL_BYTES),
        .IMAGE_BYTES (IMAGE_BYTES)
    ) u_fill (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_phase      (w_phase),
        .i_calib_done (i_calib_done),
        .i_mem_busy   (i_mem_busy),
        .i_ld_valid   (i_ld_valid),
        .i_ld_data    (i_ld_data),
        .o_op         (w_fl_op),
        .o_addr       (w_fl_addr),
        .o_wdata      (w_fl_wdata),
        .o_ld_taken   (o_ld_taken),
        .o_zero_done  (w_zero_done),
        .o_load_done  (w_load_done),
        .o_load_sum   (w_load_sum)
    );

    readback_verifier #(
        .IMAGE_BYTES (IMAGE_BYTES)
    ) u_verify (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_phase          (w_phase),
        .i_mem_busy       (i_mem_busy),
        .i_mem_rdata      (i_mem_rdata),
        .i_load_sum       (w_load_sum),
        .o_op             (w_rb_op),
        .o_addr           (w_rb_addr),
        .o_verify_done    (w_verify_done),
        .o_checksum_match (o_checksum_match)
    );

    mem_port_arbiter u_arb (
        .i_phase     (w_phase),
        .i_fl_op     (w_fl_op),
        .i_fl_addr   (w_fl_addr),
        .i_fl_wdata  (w_fl_wdata),
        .i_rb_op     (w_rb_op),
        .i_rb_addr   (w_rb_addr),
        .i_rd_en     (i_rd_en),
        .i_wr_en     (i_wr_en),
        .i_addr      (i_addr),
        .i_data      (i_data),
        .i_ctrl      (i_ctrl),
        .i_mem_rdata (i_mem_rdata),
        .i_mem_busy  (i_mem_busy),
        .o_mem_rd    (o_mem_rd),
        .o_mem_wr    (o_mem_wr),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_mem_be    (o_mem_be),
        .o_data      (o_data),
        .o_busy      (o_busy)
    );

endmodule

/* design/mem_port_arbiter.sv */
/*
 * memory port arbiter
 * boot engines own the port until run, then the CPU bus passes through
 */
`timescale 1ns/10ps

module mem_port_arbiter (
    input  mem_maint_pkg::boot_phase_e        i_phase,
    input  mem_maint_pkg::mem_op_e            i_fl_op,
    input  logic [mem_maint_pkg::ADDR_W-1:0]  i_fl_addr,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_fl_wdata,
    input  mem_maint_pkg::mem_op_e            i_rb_op,
    input  logic [mem_maint_pkg::ADDR_W-1:0]  i_rb_addr,
    input  logic                              i_rd_en,
    input  logic                              i_wr_en,
    input  logic [mem_maint_pkg::ADDR_W-1:0]  i_addr,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_data,
    input  logic [mem_maint_pkg::BE_W-1:0]    i_ctrl,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_mem_rdata,
    input  logic                              i_mem_busy,
    output logic                              o_mem_rd,
    output logic                              o_mem_wr,
    output logic [mem_maint_pkg::ADDR_W-1:0]  o_mem_addr,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_mem_wdata,
    output logic [mem_maint_pkg::BE_W-1:0]    o_mem_be,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_data,
    output logic                              o_busy
);
    import mem_maint_pkg::*;

    logic    w_run;
    mem_op_e w_op;

    assign w_run = (i_phase == PH_RUN);

    always_comb begin
        case (i_phase)
            PH_ZERO, PH_LOAD: w_op = i_fl_op;
            PH_VERIFY:        w_op = i_rb_op;
            default:          w_op = OP_NONE;   // reset and run
        endcase
    end

    assign o_mem_rd    = w_run ? i_rd_en : (w_op == OP_READ);
    assign o_mem_wr    = w_run ? i_wr_en : (w_op == OP_WRITE);
    assign o_mem_addr  = w_run ? (i_addr & ADDR_MASK)
                       : (i_phase == PH_VERIFY) ? i_rb_addr : i_fl_addr;
    assign o_mem_wdata = w_run ? i_data : i_fl_wdata;
    assign o_mem_be    = w_run ? i_ctrl : '1;   // full words during boot

    assign o_data = i_mem_rdata;
    assign o_busy = w_run ? i_mem_busy : 1'b1;  // bus locked out until run

endmodule

/* design/readback_verifier.sv */
/*
 * read-back verifier
 * reads the boot image back, sums it and compares with the load sum
 */
`timescale 1ns/10ps

module readback_verifier #(
    parameter int IMAGE_BYTES = 128
) (
    input  logic                              clk,
    input  logic                              i_rst,
    input  mem_maint_pkg::boot_phase_e        i_phase,
    input  logic                              i_mem_busy,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_mem_rdata,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_load_sum,
    output mem_maint_pkg::mem_op_e            o_op,
    output logic [mem_maint_pkg::ADDR_W-1:0]  o_addr,
    output logic                              o_verify_done,
    output logic                              o_checksum_match
);
    import mem_maint_pkg::*;

    typedef enum logic [1:0] {
        RB_IDLE,
        RB_STROBE,
        RB_WAIT
    } rb_state_e;

    rb_state_e          r_state;
    logic [DATA_W-1:0]  r_sum;
    logic [DATA_W-1:0]  w_sum_next;
    logic [ADDR_W-1:0]  w_next;

    assign w_sum_next = r_sum + i_mem_rdata;   // rdata valid on the completion cycle
    assign w_next     = o_addr + ADDR_W'(WORD_BYTES);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            r_state          <= RB_IDLE;
            o_op             <= OP_NONE;
            o_addr           <= '0;
            r_sum            <= '0;
            o_verify_done    <= 1'b0;
            o_checksum_match <= 1'b0;
        end else begin
            case (r_state)
                RB_IDLE: begin
                    if (i_phase == PH_VERIFY && !o_verify_done && !i_mem_busy) begin
                        o_op    <= OP_READ;
                        r_state <= RB_STROBE;
                    end
                end
                RB_STROBE: begin
                    if (i_mem_busy) begin
                        o_op    <= OP_NONE;   // drop once accepted
                        r_state <= RB_WAIT;
                    end
                end
                default: begin
                    if (!i_mem_busy) begin
                        r_sum   <= w_sum_next;
                        o_addr  <= w_next;
                        r_state <= RB_IDLE;
                        if (w_next == ADDR_W'(IMAGE_BYTES)) begin
                            o_checksum_match <= (w_sum_next == i_load_sum);
                            o_verify_done    <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memory maintenance testbench with verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_maint -f compile.f -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    || { echo "simulation build or run failed"; exit 1; }

grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && exit 1 || exit 0

/* testbench/mem_maint_checker.sv */
/*
 * memory maintenance checker
 * watches the DUT ports, keeps a shadow memory and its own sums
 */
`timescale 1ns/10ps

module mem_maint_checker #(
    parameter int FILL_BYTES  = 256,
    parameter int IMAGE_BYTES = 128,
    parameter int CPU_OPS     = 40
) (
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_mem_rd,
    input  logic        i_mem_wr,
    input  logic [31:0] i_mem_addr,
    input  logic [31:0] i_mem_wdata,
    input  logic [3:0]  i_mem_be,
    input  logic [31:0] i_mem_rdata,
    input  logic        i_mem_busy,
    input  logic        i_calib_done,
    input  logic        i_ld_taken,
    input  logic [31:0] i_ld_data,
    input  logic        i_init_done,
    input  logic        i_checksum_match,
    input  logic        i_busy,
    input  logic        i_rd_en,
    input  logic        i_wr_en,
    input  logic [31:0] i_addr,
    input  logic [31:0] i_data,
    input  logic [3:0]  i_ctrl,
    input  logic [31:0] i_cpu_rdata,
    input  logic        i_expect_match,
    input  logic        i_finish,
    output logic        o_done,
    output int          o_failed
);
    localparam int FILL_WORDS  = FILL_BYTES / 4;
    localparam int IMAGE_WORDS = IMAGE_BYTES / 4;
    localparam int C_ZERO = 0, C_LOAD = 1, C_VERIFY = 2, C_HAND = 3, C_CPU = 4, C_HS = 5;

    logic [31:0] shadow [0:63];
    logic [31:0] taken_q [$];
    int          errs [6];
    int          boot_no, zero_cnt, load_cnt, rd_cnt, cpu_cnt;
    int          tests_run, tests_failed, errors;
    logic [31:0] ld_sum, rd_sum, p_addr, p_data;
    logic        pend, pend_wr, pend_seen, pend_boot, prev_strobe, prev_init;

    initial begin
        o_done = 1'b0;
        o_failed = 0;
        boot_no = 0;
        cpu_cnt = 0;
        tests_run = 0;
        tests_failed = 0;
        errors = 0;
        foreach (errs[i]) errs[i] = 0;
    end

    task automatic flag(input string msg, input int cat);
        $display("error at %0d ns: %s", $time, msg);
        errs[cat]++;
        errors++;
    endtask

    task automatic note(input string msg, input int cat);
        $display("%s", msg);
        errs[cat]++;
        errors++;
    endtask

    task automatic report(input string name, input int cat);
        tests_run++;
        if (errs[cat] != 0) tests_failed++;
        $display("test %-22s %s", name, (errs[cat] == 0) ? "ok" : "failed");
        errs[cat] = 0;
    endtask

    task automatic write_shadow(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] be);
        for (int b = 0; b < 4; b++)
            if (be[b]) shadow[addr[7:2]][8*b +: 8] = data[8*b +: 8];
    endtask

    task automatic accept();
        logic [31:0] want;
        pend = 1'b1;
        pend_seen = 1'b0;
        pend_wr = i_mem_wr;
        pend_boot = !i_init_done;
        p_addr = i_mem_addr;
        p_data = i_mem_wdata;
        if (pend_boot) begin
            if (i_mem_be != 4'hf) flag("boot access without full byte enables", C_HAND);
            if (!i_calib_done) note("memory access started before calibration", C_ZERO);
            if (i_mem_wr && taken_q.size() == 0) begin
                if (i_mem_addr != 32'(zero_cnt * 4) || i_mem_wdata != 32'h0)
                    flag($sformatf("zero fill wrote %h at %h", i_mem_wdata, i_mem_addr), C_ZERO);
                write_shadow(32'(zero_cnt * 4), 32'h0, 4'hf);
                zero_cnt++;
            end else if (i_mem_wr) begin
                if (load_cnt >= taken_q.size()) begin
                    note("load write without a taken loader word", C_LOAD);
                end else begin
                    if (i_mem_addr != 32'(load_cnt * 4) || i_mem_wdata != taken_q[load_cnt])
                        flag($sformatf("load wrote %h at %h", i_mem_wdata, i_mem_addr),
                             C_LOAD);
                    write_shadow(32'(load_cnt * 4), taken_q[load_cnt], 4'hf);
                end
                load_cnt++;
            end else begin
                if (i_mem_addr != 32'(rd_cnt * 4))
                    flag($sformatf("verify read at %h, want %0h", i_mem_addr, rd_cnt * 4),
                         C_VERIFY);
                rd_cnt++;
            end
        end else begin
            want = i_addr & 32'h03ff_ffff;   // low 26 bits reach memory
            if (i_mem_addr != want || i_mem_be != i_ctrl || i_mem_rd != i_rd_en
                || i_mem_wr != i_wr_en || (i_mem_wr && i_mem_wdata != i_data))
                flag($sformatf("cpu access at %h not passed through", i_addr), C_CPU);
            if (i_wr_en) write_shadow(want, i_data, i_ctrl);
            cpu_cnt++;
        end
    endtask

    task automatic track_pending();
        if (i_mem_addr != p_addr || (pend_wr && i_mem_wdata != p_data))
            flag("address or data changed before completion", C_HS);
        if (i_mem_busy) begin
            pend_seen = 1'b1;
        end else if (pend_seen) begin
            pend = 1'b0;   // completion cycle
            if (!pend_wr && pend_boot)
                rd_sum = rd_sum + i_mem_rdata;
            else if (!pend_wr && i_cpu_rdata !== shadow[p_addr[7:2]])
                flag($sformatf("cpu read %h at %h, want %h", i_cpu_rdata, p_addr,
                               shadow[p_addr[7:2]]), C_CPU);
        end
    endtask

    task automatic end_of_boot();
        if (taken_q.size() != IMAGE_WORDS || load_cnt != IMAGE_WORDS)
            note($sformatf("load took %0d words and wrote %0d, expected %0d",
                           taken_q.size(), load_cnt, IMAGE_WORDS), C_LOAD);
        report($sformatf("boot%0d load", boot_no), C_LOAD);
        if (rd_cnt != IMAGE_WORDS)
            note($sformatf("verify read %0d words instead of %0d", rd_cnt, IMAGE_WORDS),
                 C_VERIFY);
        if (i_checksum_match !== (ld_sum == rd_sum))
            flag($sformatf("checksum flag %b with sums %h and %h", i_checksum_match,
                           ld_sum, rd_sum), C_VERIFY);
        if ((ld_sum == rd_sum) != i_expect_match)
            note("the image corruption did not show as expected", C_VERIFY);
        report($sformatf("boot%0d verify", boot_no), C_VERIFY);
        report($sformatf("boot%0d handover", boot_no), C_HAND);
    endtask

    always @(posedge clk) begin
        logic strobe;
        strobe = i_mem_rd || i_mem_wr;
        if (i_rst) begin
            zero_cnt = 0;
            load_cnt = 0;
            rd_cnt = 0;
            ld_sum = '0;
            rd_sum = '0;
            taken_q.delete();
            pend = 1'b0;
            prev_strobe = 1'b0;
            prev_init = 1'b0;
        end else begin
            if (!i_init_done && !i_busy) flag("cpu bus not busy during boot", C_HAND);
            if (strobe && !prev_strobe && i_mem_busy) flag("strobe rose while busy", C_HS);
            if (i_ld_taken) begin
                taken_q.push_back(i_ld_data);
                ld_sum = ld_sum + i_ld_data;   // wraps like the hardware sum
                if (taken_q.size() == 1) begin
                    boot_no++;
                    if (zero_cnt != FILL_WORDS)
                        note($sformatf("zero fill wrote %0d words instead of %0d",
                                       zero_cnt, FILL_WORDS), C_ZERO);
                    report($sformatf("boot%0d zero fill", boot_no), C_ZERO);
                end
            end
            if (pend)
                track_pending();
            else if (strobe && !i_mem_busy)
                accept();
            if (i_init_done && !prev_init) end_of_boot();
            prev_strobe = strobe;
            prev_init = i_init_done;
        end
        if (i_finish && !o_done) begin
            if (cpu_cnt != CPU_OPS)
                note($sformatf("%0d cpu accesses seen instead of %0d", cpu_cnt, CPU_OPS), C_CPU);
            report("cpu run phase", C_CPU);
            report("handshake", C_HS);
            $display("tests %0d, passed %0d, failed %0d, errors %0d",
                     tests_run, tests_run - tests_failed, tests_failed, errors);
            o_failed = tests_failed;
            o_done = 1'b1;
        end
    end

endmodule

/* testbench/tb_mem_maint.sv */
/*
 * memory maintenance testbench
 * memory model with random busy, loader stream, CPU bus driver, two boots
 */
`timescale 1ns/10ps

module tb_mem_maint;

    localparam int FILL_BYTES  = 256;
    localparam int IMAGE_BYTES = 128;
    localparam int CPU_OPS     = 40;
    localparam int LIMIT = 16 + 8 * (FILL_BYTES / 4 + 2 * IMAGE_BYTES / 4 + CPU_OPS) * 2;

    logic        clk = 1'b0;
    logic        i_rst, i_rd_en, i_wr_en, i_ld_valid, i_mem_busy, i_calib_done;
    logic [31:0] i_addr, i_data, i_ld_data, i_mem_rdata;
    logic [3:0]  i_ctrl;
    logic [31:0] o_data, o_mem_addr, o_mem_wdata;
    logic [3:0]  o_mem_be;
    logic        o_busy, o_ld_taken, o_mem_rd, o_mem_wr, o_init_done, o_checksum_match;

    logic [31:0] rng_state = 32'd93702;
    logic [31:0] mem_model [0:63];
    logic        act, m_wr, cpu_owned, corrupt_armed, expect_match, finish_req, chk_done;
    logic [31:0] m_addr, m_data;
    logic [3:0]  m_be;
    int          left, cycles = 0, chk_failed;

    always #50 clk = ~clk;

    mem_maint_top #(.FILL_BYTES(FILL_BYTES), .IMAGE_BYTES(IMAGE_BYTES)) uut (
        .clk(clk), .i_rst(i_rst), .i_rd_en(i_rd_en), .i_wr_en(i_wr_en), .i_addr(i_addr),
        .i_data(i_data), .i_ctrl(i_ctrl), .o_data(o_data), .o_busy(o_busy),
        .i_ld_valid(i_ld_valid), .i_ld_data(i_ld_data), .o_ld_taken(o_ld_taken),
        .o_mem_rd(o_mem_rd), .o_mem_wr(o_mem_wr), .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata), .o_mem_be(o_mem_be), .i_mem_rdata(i_mem_rdata),
        .i_mem_busy(i_mem_busy), .i_calib_done(i_calib_done), .o_init_done(o_init_done),
        .o_checksum_match(o_checksum_match)
    );

    mem_maint_checker #(.FILL_BYTES(FILL_BYTES), .IMAGE_BYTES(IMAGE_BYTES),
                        .CPU_OPS(CPU_OPS)) u_check (
        .clk(clk), .i_rst(i_rst), .i_mem_rd(o_mem_rd), .i_mem_wr(o_mem_wr),
        .i_mem_addr(o_mem_addr), .i_mem_wdata(o_mem_wdata), .i_mem_be(o_mem_be),
        .i_mem_rdata(i_mem_rdata), .i_mem_busy(i_mem_busy), .i_calib_done(i_calib_done),
        .i_ld_taken(o_ld_taken), .i_ld_data(i_ld_data), .i_init_done(o_init_done),
        .i_checksum_match(o_checksum_match), .i_busy(o_busy), .i_rd_en(i_rd_en),
        .i_wr_en(i_wr_en), .i_addr(i_addr), .i_data(i_data), .i_ctrl(i_ctrl),
        .i_cpu_rdata(o_data), .i_expect_match(expect_match), .i_finish(finish_req),
        .o_done(chk_done), .o_failed(chk_failed)
    );

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // memory port model, busy 1 to 6 cycles, data and writes land at completion
    always @(posedge clk) begin
        logic        go, fin, rst_now;
        logic [31:0] rdata;
        logic [5:0]  flip_word;
        logic [4:0]  flip_bit;
        go = 1'b0;
        fin = 1'b0;
        rst_now = i_rst;
        rdata = '0;
        if (rst_now) begin
            act = 1'b0;
        end else if (act) begin
            if (left > 1) begin
                left--;
            end else begin
                fin = 1'b1;
                act = 1'b0;
                for (int b = 0; b < 4; b++)
                    if (m_wr && m_be[b]) mem_model[m_addr[7:2]][8*b +: 8] = m_data[8*b +: 8];
                rdata = mem_model[m_addr[7:2]];
            end
        end else if ((o_mem_rd || o_mem_wr) && !i_mem_busy) begin
            act = 1'b1;
            go = 1'b1;
            m_wr = o_mem_wr;
            m_addr = o_mem_addr;
            m_data = o_mem_wdata;
            m_be = o_mem_be;
            left = 32'(1 + xorshift() % 6);
            if (o_mem_rd && corrupt_armed && !o_init_done) begin
                flip_word = 6'(xorshift() % 32'(IMAGE_BYTES / 4));
                flip_bit = 5'(xorshift() % 32);
                mem_model[flip_word][flip_bit] = ~mem_model[flip_word][flip_bit];
                corrupt_armed = 1'b0;   // one flipped bit before verify
            end
        end
        #1;
        if (go) i_mem_busy = 1'b1;
        if (fin || rst_now) i_mem_busy = 1'b0;
        if (fin) i_mem_rdata = rdata;
    end

    // loader stream with random gaps
    initial begin : loader
        int          gap;
        logic [31:0] w;
        @(posedge clk);
        forever begin
            gap = 32'(xorshift() % 4);
            repeat (gap) @(posedge clk);
            w = xorshift();
            #1;
            i_ld_valid = 1'b1;
            i_ld_data = w;
            do @(posedge clk); while (!o_ld_taken);
            #1 i_ld_valid = 1'b0;
        end
    end

    // random CPU strobes during boot, which must never reach memory
    always @(posedge clk) begin
        logic [31:0] r;
        r = xorshift();
        #1;
        if (!cpu_owned) begin
            i_rd_en = !o_init_done && r[0];
            i_wr_en = !o_init_done && r[1];
            i_addr = r;
            i_data = ~r;
            i_ctrl = r[7:4];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic run_boot(input logic clean);
        int wait_cycles;
        @(posedge clk);
        cpu_owned = 1'b0;
        expect_match = clean;
        corrupt_armed = !clean;
        #1;
        i_rst = 1'b1;
        i_calib_done = 1'b0;
        repeat (16) @(posedge clk);
        #1 i_rst = 1'b0;
        wait_cycles = 32'(4 + xorshift() % 16);
        repeat (wait_cycles) @(posedge clk);
        #1 i_calib_done = 1'b1;
        do @(posedge clk); while (!o_init_done);
    endtask

    // one bus access, called just after a clock edge with the bus idle
    task automatic cpu_access();
        logic [31:0] r;
        r = xorshift();
        #1;
        i_rd_en = r[0];
        i_wr_en = !r[0];
        i_addr = (xorshift() & 32'hfc00_0000) | 32'({r[13:8], 2'b00});
        i_data = xorshift();
        i_ctrl = r[7:4];
        do @(posedge clk); while (!o_busy);
        #1;
        i_rd_en = 1'b0;
        i_wr_en = 1'b0;
        do @(posedge clk); while (o_busy);
    endtask

    initial begin
        i_rst = 1'b1;
        i_rd_en = 1'b0;
        i_wr_en = 1'b0;
        i_addr = '0;
        i_data = '0;
        i_ctrl = '0;
        i_ld_valid = 1'b0;
        i_ld_data = '0;
        i_mem_busy = 1'b0;
        i_mem_rdata = '0;
        i_calib_done = 1'b0;
        act = 1'b0;
        cpu_owned = 1'b0;
        corrupt_armed = 1'b0;
        expect_match = 1'b1;
        finish_req = 1'b0;
        for (int i = 0; i < 64; i++)
            mem_model[i] = 32'(i) * 32'h9e37_79b1 ^ 32'h5a5a_0000;
        run_boot(1'b1);
        cpu_owned = 1'b1;
        repeat (CPU_OPS) cpu_access();
        run_boot(1'b0);
        @(posedge clk);
        #1 finish_req = 1'b1;
        wait (chk_done);
        #1;
        if (chk_failed == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
